/* all.f */
hdl/seq_cfg_pkg.sv
hdl/seq_types_pkg.sv
hdl/slot_table.sv
hdl/slot_arbiter.sv
hdl/host_regs.sv
hdl/seq_engine.sv
hdl/magic_seq_top.sv
dv/magic_seq_chk.sv
dv/magic_seq_tb.sv

/* dv/magic_seq_chk.sv */
module magic_seq_chk (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    busy,
    input logic                    intr_en,
    input logic                    intr_flag,
    input logic                    dma_done,
    input logic [31:0]             dma_base,
    input seq_types_pkg::dma_cmd_t dma
);
    import seq_cfg_pkg::*;

    logic go_open;  // go seen, done not yet

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            go_open <= 1'b0;
        end else if (dma.go) begin
            go_open <= 1'b1;
        end else if (dma_done) begin
            go_open <= 1'b0;
        end
    end

    a_cmd_busy: assert property (@(posedge clk) disable iff (!rst_n)
        (dma.go || dma.wr) |-> busy) else $error("dma command while idle");

    a_wr_addr: assert property (@(posedge clk) disable iff (!rst_n)
        dma.wr |-> (dma.addr == dma_base || dma.addr == dma_base + DATA_W'(DMA_SIZE_OFS)))
        else $error("dma write outside the descriptor registers");

    a_one_go: assert property (@(posedge clk) disable iff (!rst_n)
        dma.go |-> !go_open) else $error("second go before dma_done");

    a_irq_en: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(intr_flag) |-> $past(intr_en)) else $error("irq rose with interrupts off");

endmodule

bind seq_engine magic_seq_chk u_chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .busy      (busy),
    .intr_en   (intr_en),
    .intr_flag (intr_flag),
    .dma_done  (dma_done),
    .dma_base  (dma_base),
    .dma       (dma)
);

/* dv/magic_seq_tb.sv */
module magic_seq_tb;
    import seq_cfg_pkg::*;
    import seq_types_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int WORDS      = 19;   // end, base, intr_en, 8 x (src, size)
    localparam int MAX_TESTS  = 16;

    logic      clk;
    logic      rst_n;
    host_req_t host_req;
    host_rsp_t host_rsp;
    dma_cmd_t  dma;
    logic      dma_done;
    logic      hw_start;
    logic      hw_intr_clear;
    logic      irq;

    logic [31:0] vec [1 + MAX_TESTS*WORDS];
    int          num_tests;
    int          errors;
    logic        loaded;
    logic        waiting;     // go issued, dma_done not yet given
    logic        exp_go [$];  // expected dma commands in order
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    int          exp_step [$];

    magic_seq_top #(
        .SLOT_IDX_W (DEF_SLOT_IDX_W)
    ) UUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .host_req      (host_req),
        .host_rsp      (host_rsp),
        .dma           (dma),
        .dma_done      (dma_done),
        .hw_start      (hw_start),
        .hw_intr_clear (hw_intr_clear),
        .irq           (irq)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (exp === act) else begin
            errors++;
            $display("CHECK FAILED t=%0t %s expected=%h actual=%h", $time, name, exp, act);
        end
    endtask

    // one strobed request, then wait for done
    task automatic host_access(input logic wr, input logic [ADDR_W-1:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata);
        int n;
        n = 0;
        rdata = '0;
        @(negedge clk);
        host_req = '{wr: wr, rd: !wr, addr: addr, wdata: wdata};
        @(negedge clk);
        host_req = '0;
        while (!host_rsp.done && n < 20) begin
            @(negedge clk);
            n++;
        end
        assert (host_rsp.done) else begin
            errors++;
            $display("host request to %h got no done response", addr);
        end
        rdata = host_rsp.rdata;
    endtask

    task automatic read_check(input string name, input logic [ADDR_W-1:0] addr,
                              input logic [31:0] exp);
        logic [31:0] rd;
        host_access(1'b0, addr, '0, rd);
        check_value(name, exp, rd);
    endtask

    ////////////////////////////////////////
    // dma model and command scoreboard

    initial begin : dma_model
        int unsigned countdown;
        int          cycle;
        int          last_cycle;
        countdown  = 0;
        cycle      = 0;
        last_cycle = 0;
        waiting    = 1'b0;
        forever begin
            @(negedge clk);
            cycle++;
            dma_done = 1'b0;
            if (dma.wr || dma.go) begin
                assert (!(waiting && dma.wr)) else begin
                    errors++;
                    $display("dma write at t=%0t while a go was outstanding", $time);
                end
                if (exp_go.size() == 0) begin
                    errors++;
                    $display("unexpected dma command at t=%0t", $time);
                end else begin
                    check_value("dma.go", 32'(exp_go[0]), 32'(dma.go));
                    if (dma.go) begin
                        check_value("dma.go_idx", exp_data[0], 32'(dma.go_idx));
                    end else begin
                        check_value("dma.addr", exp_addr[0], dma.addr);
                        check_value("dma.data", exp_data[0], dma.data);
                    end
                    if (exp_step[0] != 0) begin
                        check_value("dma command spacing", 32'(last_cycle + 1), 32'(cycle));
                    end
                    void'(exp_go.pop_front());
                    void'(exp_addr.pop_front());
                    void'(exp_data.pop_front());
                    void'(exp_step.pop_front());
                end
                last_cycle = cycle;
            end
            if (countdown != 0) begin
                countdown--;
                if (countdown == 0) begin
                    dma_done = 1'b1;
                    waiting  = 1'b0;
                end
            end
            if (dma.go) begin
                countdown = $urandom_range(6, 1);
                waiting   = 1'b1;
            end
        end
    end

    initial begin : watchdog
        wait (loaded);
        #(num_tests * 400 * CLK_PERIOD);
        $display("timeout, the tests did not finish in time");
        $display("ERRORS FOUND");
        $finish;
    end

    ////////////////////////////////////////
    // main sequence

    initial begin : main_seq
        int          b;
        int          end_cnt;
        logic [31:0] base;
        logic [31:0] ien;
        logic [31:0] size_mask;
        logic [31:0] rd;
        int          n;
        void'($urandom(60));
        host_req      = '0;
        dma_done      = 1'b0;
        hw_start      = 1'b0;
        hw_intr_clear = 1'b0;
        rst_n         = 1'b0;
        errors        = 0;
        loaded        = 1'b0;
        size_mask     = (32'd1 << SIZE_W) - 32'd1;
        $readmemh("dv/magic_seq_tests.txt", vec);
        num_tests = int'(vec[0]);
        if (num_tests < 1 || num_tests > MAX_TESTS) begin
            errors++;
            $display("test file holds no usable test count");
            num_tests = 0;
        end
        loaded = 1'b1;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        check_value("irq", 32'd0, 32'(irq));
        for (int t = 0; t < num_tests; t++) begin
            b       = 1 + t*WORDS;
            end_cnt = int'(vec[b]);
            base    = vec[b+1];
            ien     = vec[b+2];
            host_access(1'b1, REG_END_CNT, 32'(end_cnt), rd);
            host_access(1'b1, REG_DMA_BASE, base, rd);
            host_access(1'b1, REG_INTR_EN, ien, rd);
            for (int i = 0; i <= end_cnt; i++) begin
                host_access(1'b1, SLOT_BASE + ADDR_W'(8*i), vec[b+3+2*i], rd);
                host_access(1'b1, SLOT_BASE + ADDR_W'(8*i+4), vec[b+4+2*i], rd);
            end
            read_check("REG_END_CNT", REG_END_CNT, 32'(end_cnt));
            read_check("REG_DMA_BASE", REG_DMA_BASE, base);
            read_check("REG_INTR_EN", REG_INTR_EN, ien);
            for (int i = 0; i <= end_cnt; i++) begin
                read_check("slot src", SLOT_BASE + ADDR_W'(8*i), vec[b+3+2*i]);
                read_check("slot size", SLOT_BASE + ADDR_W'(8*i+4), vec[b+4+2*i] & size_mask);
                exp_go.push_back(1'b0);
                exp_addr.push_back(base);
                exp_data.push_back(vec[b+3+2*i]);
                exp_step.push_back(0);
                exp_go.push_back(1'b0);
                exp_addr.push_back(base + 32'd4);
                exp_data.push_back(vec[b+4+2*i] & size_mask);
                exp_step.push_back(1);
                exp_go.push_back(1'b1);
                exp_addr.push_back('0);
                exp_data.push_back(32'(i));
                exp_step.push_back(2);
            end
            // odd tests use the hardware start and clear strobes
            if (t % 2 == 1) begin
                @(negedge clk);
                hw_start = 1'b1;
                @(negedge clk);
                hw_start = 1'b0;
            end else begin
                host_access(1'b1, REG_CTRL, 32'd1, rd);
            end
            while (!waiting) @(posedge clk);
            read_check("REG_MAIN_CNT", REG_MAIN_CNT, 32'd0);
            if (end_cnt > 0) begin
                host_access(1'b1, REG_CTRL, 32'd1, rd);  // ignored while busy
            end
            read_check("slot src during run", SLOT_BASE + ADDR_W'(8*end_cnt),
                       vec[b+3+2*end_cnt]);
            n = 0;
            rd = 32'd1;
            while (rd[0] && n < 300) begin
                host_access(1'b0, REG_STATUS, '0, rd);
                n++;
            end
            check_value("REG_STATUS", 32'd0, rd);
            assert (exp_go.size() == 0) else begin
                errors++;
                $display("%0d expected dma commands never came", exp_go.size());
                exp_go.delete();
                exp_addr.delete();
                exp_data.delete();
                exp_step.delete();
            end
            @(negedge clk);
            check_value("irq", ien & 32'd1, 32'(irq));
            read_check("REG_INTR", REG_INTR, ien & 32'd1);
            if (t % 2 == 1) begin
                @(negedge clk);
                hw_intr_clear = 1'b1;
                @(negedge clk);
                hw_intr_clear = 1'b0;
            end else begin
                host_access(1'b1, REG_INTR, 32'd1, rd);
                @(negedge clk);
            end
            check_value("irq after clear", 32'd0, 32'(irq));
        end
        repeat (4) @(negedge clk);
        $display("error count: %0d", errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* dv/magic_seq_tests.txt */
// first word: number of tests
// then per test: end_cnt dma_base intr_en, then src size for slots 0..7
00000004
00000003 40000000 00000001 10000000 00000100 10001000 00000200 10002000 00000040 1000F000 03FFFFFF 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00002000 00000000 CAFE0000 00001234 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000007 A0000010 00000001 00000010 FFFFFFFF 00000020 00000001 00000030 0C000002 00000040 00000003 00000050 00000004 00000060 12345678 00000070 00000006 FFFFFFF0 00000007
00000001 00001000 00000001 80000000 00000800 80010000 04000800 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000

/* hdl/host_regs.sv */
module host_regs #(
    parameter int SLOT_IDX_W = seq_cfg_pkg::DEF_SLOT_IDX_W
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  seq_types_pkg::host_req_t       req,
    output seq_types_pkg::host_rsp_t       rsp,
    output seq_types_pkg::slot_req_t       slot_req,
    input  seq_types_pkg::slot_rsp_t       slot_rsp,
    output logic                           start,
    output logic [SLOT_IDX_W-1:0]          end_cnt,
    output logic [seq_cfg_pkg::DATA_W-1:0] dma_base,
    output logic                           intr_en,
    output logic                           intr_clr,
    input  logic                           busy,
    input  logic [SLOT_IDX_W-1:0]          main_cnt,
    input  logic                           intr_flag
);
    import seq_cfg_pkg::*;

    logic              acc;         // any host strobe
    logic              slot_hit;    // address in the slot region
    logic [ADDR_W-1:0] slot_ofs;
    logic              ctrl_acc;
    logic [DATA_W-1:0] ctrl_rdata;
    logic [DATA_W-1:0] slot_rdata;

    assign acc      = req.wr || req.rd;
    assign slot_hit = req.addr >= SLOT_BASE;
    assign slot_ofs = req.addr - SLOT_BASE;
    assign ctrl_acc = acc && !slot_hit;

    assign start    = req.wr && (req.addr == REG_CTRL) && req.wdata[0];
    assign intr_clr = req.wr && (req.addr == REG_INTR) && req.wdata[0];

    always_comb begin
        ctrl_rdata = '0;
        case (req.addr)
            REG_STATUS:   ctrl_rdata[0] = busy;
            REG_END_CNT:  ctrl_rdata[SLOT_IDX_W-1:0] = end_cnt;
            REG_DMA_BASE: ctrl_rdata = dma_base;
            REG_INTR_EN:  ctrl_rdata[0] = intr_en;
            REG_INTR:     ctrl_rdata[0] = intr_flag;
            REG_MAIN_CNT: ctrl_rdata[SLOT_IDX_W-1:0] = main_cnt;
            default:      ctrl_rdata = '0;  // REG_CTRL reads as zero
        endcase
    end

    assign slot_rdata = slot_req.field ? DATA_W'(slot_rsp.entry.size)
                                       : DATA_W'(slot_rsp.entry.src_addr);

    ////////////////////////////////////////
    // control bank

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            end_cnt  <= '0;
            dma_base <= '0;
            intr_en  <= 1'b0;
        end else if (req.wr) begin
            case (req.addr)
                REG_END_CNT:  end_cnt  <= req.wdata[SLOT_IDX_W-1:0];
                REG_DMA_BASE: dma_base <= req.wdata;
                REG_INTR_EN:  intr_en  <= req.wdata[0];
                default: ;
            endcase
        end
    end

    ////////////////////////////////////////
    // slot access, held until the arbiter answers

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_req <= '0;
        end else if (slot_rsp.valid) begin
            slot_req.valid <= 1'b0;
        end else if (acc && slot_hit) begin
            slot_req.valid <= 1'b1;
            slot_req.we    <= req.wr;
            slot_req.idx   <= slot_ofs[MAX_SLOT_IDX_W+2:3];  // 8 bytes per slot
            slot_req.field <= slot_ofs[2];
            slot_req.wdata <= req.wdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp <= '0;
        end else begin
            rsp.done <= ctrl_acc || slot_rsp.valid;  // once per request
            if (ctrl_acc) begin
                rsp.rdata <= ctrl_rdata;
            end else if (slot_rsp.valid) begin
                rsp.rdata <= slot_rdata;
            end
        end
    end

endmodule

/* hdl/magic_seq_top.sv */
module magic_seq_top #(
    parameter int SLOT_IDX_W = seq_cfg_pkg::DEF_SLOT_IDX_W
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  seq_types_pkg::host_req_t host_req,
    output seq_types_pkg::host_rsp_t host_rsp,
    output seq_types_pkg::dma_cmd_t  dma,
    input  logic                     dma_done,
    input  logic                     hw_start,
    input  logic                     hw_intr_clear,
    output logic                     irq
);
    import seq_cfg_pkg::*;
    import seq_types_pkg::*;

    slot_req_t             host_slot_req;
    slot_rsp_t             host_slot_rsp;
    slot_req_t             eng_slot_req;
    slot_rsp_t             eng_slot_rsp;
    slot_req_t             tbl_req;
    slot_rsp_t             tbl_rsp;
    logic                  start;
    logic                  intr_en;
    logic                  intr_clr;
    logic                  busy;
    logic                  intr_flag;
    logic [SLOT_IDX_W-1:0] end_cnt;
    logic [SLOT_IDX_W-1:0] main_cnt;
    logic [DATA_W-1:0]     dma_base;

    assign irq = intr_flag;

    ////////////////////////////////////////
    // host side and sequence engine

    host_regs #(
        .SLOT_IDX_W (SLOT_IDX_W)
    ) u_host_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (host_req),
        .rsp       (host_rsp),
        .slot_req  (host_slot_req),
        .slot_rsp  (host_slot_rsp),
        .start     (start),
        .end_cnt   (end_cnt),
        .dma_base  (dma_base),
        .intr_en   (intr_en),
        .intr_clr  (intr_clr),
        .busy      (busy),
        .main_cnt  (main_cnt),
        .intr_flag (intr_flag)
    );

    seq_engine #(
        .SLOT_IDX_W (SLOT_IDX_W)
    ) u_seq_engine (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .hw_start      (hw_start),
        .hw_intr_clear (hw_intr_clear),
        .intr_clr      (intr_clr),
        .end_cnt       (end_cnt),
        .dma_base      (dma_base),
        .intr_en       (intr_en),
        .slot_req      (eng_slot_req),
        .slot_rsp      (eng_slot_rsp),
        .dma           (dma),
        .dma_done      (dma_done),
        .busy          (busy),
        .main_cnt      (main_cnt),
        .intr_flag     (intr_flag)
    );

    ////////////////////////////////////////
    // shared slot table

    slot_arbiter u_slot_arbiter (
        .clk      (clk),
        .rst_n    (rst_n),
        .eng_req  (eng_slot_req),
        .host_req (host_slot_req),
        .eng_rsp  (eng_slot_rsp),
        .host_rsp (host_slot_rsp),
        .tbl_req  (tbl_req),
        .tbl_rsp  (tbl_rsp)
    );

    slot_table #(
        .SLOT_IDX_W (SLOT_IDX_W)
    ) u_slot_table (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (tbl_req),
        .rsp   (tbl_rsp)
    );

endmodule

/* hdl/seq_cfg_pkg.sv */
package seq_cfg_pkg;

    localparam int ADDR_W         = 16;  // host address
    localparam int DATA_W         = 32;  // host and dma data
    localparam int SRC_ADDR_W     = 32;
    localparam int SIZE_W         = 26;
    localparam int DEF_SLOT_IDX_W = 3;   // 8 slots
    localparam int MAX_SLOT_IDX_W = 8;   // index width of the largest table

    ////////////////////////////////////////
    // control bank

    localparam logic [ADDR_W-1:0] REG_CTRL     = 16'h0000;  // write 1 in bit 0 to start
    localparam logic [ADDR_W-1:0] REG_STATUS   = 16'h0004;  // bit 0 busy
    localparam logic [ADDR_W-1:0] REG_END_CNT  = 16'h0008;
    localparam logic [ADDR_W-1:0] REG_DMA_BASE = 16'h000C;
    localparam logic [ADDR_W-1:0] REG_INTR_EN  = 16'h0010;
    localparam logic [ADDR_W-1:0] REG_INTR     = 16'h0014;  // write 1 to clear
    localparam logic [ADDR_W-1:0] REG_MAIN_CNT = 16'h0018;

    ////////////////////////////////////////
    // slot region, 8 bytes per slot with the size at +4

    localparam logic [ADDR_W-1:0] SLOT_BASE    = 16'h0100;
    localparam int                DMA_SIZE_OFS = 4;  // size register above dma base

endpackage

/* hdl/seq_engine.sv */
module seq_engine #(
    parameter int SLOT_IDX_W = seq_cfg_pkg::DEF_SLOT_IDX_W
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           start,
    input  logic                           hw_start,
    input  logic                           hw_intr_clear,
    input  logic                           intr_clr,
    input  logic [SLOT_IDX_W-1:0]          end_cnt,
    input  logic [seq_cfg_pkg::DATA_W-1:0] dma_base,
    input  logic                           intr_en,
    output seq_types_pkg::slot_req_t       slot_req,
    input  seq_types_pkg::slot_rsp_t       slot_rsp,
    output seq_types_pkg::dma_cmd_t        dma,
    input  logic                           dma_done,
    output logic                           busy,
    output logic [SLOT_IDX_W-1:0]          main_cnt,
    output logic                           intr_flag
);
    import seq_cfg_pkg::*;

    // each descriptor state is the cycle its strobe is on the bus
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH,
        ST_WR_SRC,
        ST_WR_SIZE,
        ST_GO,
        ST_WAIT,
        ST_FINISH
    } state_t;

    state_t                state;
    logic [SLOT_IDX_W-1:0] cnt;       // slot being worked on
    logic [SIZE_W-1:0]     size_q;    // size held across the source write
    logic                  run_req;
    logic                  in_wait;
    logic                  last_done;

    assign run_req   = start || hw_start;
    assign in_wait   = (state == ST_GO) || (state == ST_WAIT);
    assign last_done = in_wait && dma_done && (cnt == end_cnt);
    assign busy      = (state != ST_IDLE) && (state != ST_FINISH);
    assign main_cnt  = cnt;

    assign slot_req.valid = (state == ST_FETCH);
    assign slot_req.we    = 1'b0;
    assign slot_req.idx   = MAX_SLOT_IDX_W'(cnt);
    assign slot_req.field = 1'b0;
    assign slot_req.wdata = '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= ST_IDLE;
            cnt    <= '0;
            size_q <= '0;
            dma    <= '0;
        end else begin
            dma.wr <= 1'b0;
            dma.go <= 1'b0;
            case (state)
                ST_IDLE, ST_FINISH: begin
                    if (run_req) begin
                        cnt   <= '0;
                        state <= ST_FETCH;
                    end else begin
                        state <= ST_IDLE;
                    end
                end
                ST_FETCH: begin
                    if (slot_rsp.valid) begin
                        dma.wr   <= 1'b1;
                        dma.addr <= dma_base;
                        dma.data <= DATA_W'(slot_rsp.entry.src_addr);
                        size_q   <= slot_rsp.entry.size;
                        state    <= ST_WR_SRC;
                    end
                end
                ST_WR_SRC: begin
                    dma.wr   <= 1'b1;
                    dma.addr <= dma_base + DATA_W'(DMA_SIZE_OFS);
                    dma.data <= DATA_W'(size_q);
                    state    <= ST_WR_SIZE;
                end
                ST_WR_SIZE: begin
                    dma.go     <= 1'b1;
                    dma.go_idx <= MAX_SLOT_IDX_W'(cnt);
                    state      <= ST_GO;
                end
                default: begin  // go issued, wait for the dma as long as it takes
                    if (last_done) begin
                        state <= ST_FINISH;
                    end else if (dma_done) begin
                        cnt   <= cnt + 1'b1;
                        state <= ST_FETCH;
                    end else begin
                        state <= ST_WAIT;
                    end
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // interrupt flag

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            intr_flag <= 1'b0;
        end else if (last_done && intr_en) begin
            intr_flag <= 1'b1;
        end else if (intr_clr || hw_intr_clear) begin
            intr_flag <= 1'b0;
        end
    end

endmodule

/* hdl/seq_types_pkg.sv */
package seq_types_pkg;

    typedef struct packed {
        logic                           wr;
        logic                           rd;
        logic [seq_cfg_pkg::ADDR_W-1:0] addr;
        logic [seq_cfg_pkg::DATA_W-1:0] wdata;
    } host_req_t;

    typedef struct packed {
        logic                           done;   // one pulse per request
        logic [seq_cfg_pkg::DATA_W-1:0] rdata;
    } host_rsp_t;

    typedef struct packed {
        logic [seq_cfg_pkg::SRC_ADDR_W-1:0] src_addr;
        logic [seq_cfg_pkg::SIZE_W-1:0]     size;
    } slot_entry_t;

    typedef struct packed {
        logic                                   valid;  // held until the response
        logic                                   we;
        logic [seq_cfg_pkg::MAX_SLOT_IDX_W-1:0] idx;
        logic                                   field;  // 0 source, 1 size
        logic [seq_cfg_pkg::DATA_W-1:0]         wdata;
    } slot_req_t;

    typedef struct packed {
        logic        valid;
        slot_entry_t entry;
    } slot_rsp_t;

    typedef struct packed {
        logic                                   wr;
        logic [seq_cfg_pkg::DATA_W-1:0]         addr;
        logic [seq_cfg_pkg::DATA_W-1:0]         data;
        logic                                   go;
        logic [seq_cfg_pkg::MAX_SLOT_IDX_W-1:0] go_idx;
    } dma_cmd_t;

endpackage

/* hdl/slot_arbiter.sv */
module slot_arbiter (
    input  logic                     clk,
    input  logic                     rst_n,
    input  seq_types_pkg::slot_req_t eng_req,
    input  seq_types_pkg::slot_req_t host_req,
    output seq_types_pkg::slot_rsp_t eng_rsp,
    output seq_types_pkg::slot_rsp_t host_rsp,
    output seq_types_pkg::slot_req_t tbl_req,
    input  seq_types_pkg::slot_rsp_t tbl_rsp
);
    logic pend;      // a table request is in flight
    logic own_host;  // owner of the request in flight
    logic free;
    logic eng_ok;
    logic host_ok;
    logic gnt_eng;
    logic gnt_host;

    // the table frees up in the cycle its answer comes back, and the
    // requester being answered there is still valid, so it is masked
    assign free     = !pend || tbl_rsp.valid;
    assign eng_ok   = eng_req.valid && !(pend && !own_host);
    assign host_ok  = host_req.valid && !(pend && own_host);
    assign gnt_eng  = free && eng_ok;              // engine has priority
    assign gnt_host = free && host_ok && !eng_ok;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend     <= 1'b0;
            own_host <= 1'b0;
            tbl_req  <= '0;
        end else begin
            if (gnt_eng) begin
                tbl_req <= eng_req;
            end else if (gnt_host) begin
                tbl_req <= host_req;
            end else begin
                tbl_req <= '0;  // one cycle per grant
            end

            if (gnt_eng || gnt_host) begin
                pend     <= 1'b1;
                own_host <= gnt_host;
            end else if (tbl_rsp.valid) begin
                pend <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // response steering

    always_comb begin
        eng_rsp  = '0;
        host_rsp = '0;
        if (own_host) begin
            host_rsp = tbl_rsp;
        end else begin
            eng_rsp = tbl_rsp;
        end
    end

endmodule

/* hdl/slot_table.sv */
module slot_table #(
    parameter int SLOT_IDX_W = seq_cfg_pkg::DEF_SLOT_IDX_W
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  seq_types_pkg::slot_req_t req,
    output seq_types_pkg::slot_rsp_t rsp
);
    import seq_cfg_pkg::*;
    import seq_types_pkg::*;

    localparam int DEPTH = 1 << SLOT_IDX_W;

    slot_entry_t           mem [DEPTH];
    logic [SLOT_IDX_W-1:0] idx;        // upper index bits alias onto the table
    logic                  rsp_valid;
    slot_entry_t           rsp_entry;

    assign idx       = req.idx[SLOT_IDX_W-1:0];
    assign rsp.valid = rsp_valid;
    assign rsp.entry = rsp_entry;

    always_ff @(posedge clk) begin
        if (req.valid && req.we) begin
            if (req.field) begin
                mem[idx].size <= req.wdata[SIZE_W-1:0];  // size is truncated to SIZE_W
            end else begin
                mem[idx].src_addr <= req.wdata[SRC_ADDR_W-1:0];
            end
        end
        rsp_entry <= mem[idx];  // whole entry, one cycle later
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= req.valid;  // every request is answered, writes too
        end
    end

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module magic_seq_tb -o sim_magic_seq
./obj_dir/sim_magic_seq > sim.log 2>&1 || true
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
    exit 1
fi
if ! grep -q "NO ERRORS" sim.log; then
    exit 1
fi
exit 0
